//--- Makefile
SIM       ?= verilator
TOP       := tb_fetch
RTL_TOP   := fetch_top
FLIST     := rv_fetch.f
FLAGS     := --binary --timing --assert -j 0
LINTFLAGS := --lint-only --timing --assert -Wall
LOG       := sim.log
OBJ       := obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) -o $(TOP)

run: build
	./$(OBJ)/$(TOP) | tee $(LOG)
	grep -q "STATUS: PASS" $(LOG)

lint:
	$(SIM) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ) $(LOG)

//--- logic/fetch_axi_rd.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_axi_rd #(
	// 1 to 4 reads in flight
	parameter int MAX_OUTSTANDING = 2
) (
	input  wire logic                 clk,
	input  wire logic                 rst_n,
	input  wire logic                 req_valid,
	input  wire fetch_pkg::fetch_req_t req,
	output logic                      req_ready,
	output logic                      ar_valid,
	output fetch_pkg::addr_t          ar_addr,
	output logic [2:0]                ar_prot,
	input  wire logic                 ar_ready,
	input  wire logic                 r_valid,
	input  wire logic [63:0]          r_data,
	input  wire logic [1:0]           r_resp,
	output logic                      r_ready,
	output logic                      rsp_valid,
	output fetch_pkg::fetch_rsp_t     rsp,
	input  wire logic                 rsp_ready
);

	import fetch_pkg::*;

	localparam int PTR_W = (MAX_OUTSTANDING > 1) ? $clog2(MAX_OUTSTANDING) : 1;
	localparam int CNT_W = $clog2(MAX_OUTSTANDING + 1);
	localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(MAX_OUTSTANDING - 1);
	localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(MAX_OUTSTANDING);

	// tags of issued reads, oldest at rd_ptr_q
	fetch_req_t       tag_mem [MAX_OUTSTANDING];
	fetch_req_t       tag_head;
	logic [PTR_W-1:0] wr_ptr_q;
	logic [PTR_W-1:0] rd_ptr_q;
	logic [CNT_W-1:0] cnt_q;
	logic             ar_hold_q;
	addr_t            ar_hold_addr_q;
	logic             req_fire;
	logic             r_fire;
	logic             tag_any;

	// *************************************
	// AR channel
	// *************************************

	// no new request while an AR beat is still waiting
	assign req_ready = (cnt_q != CNT_FULL) & ~ar_hold_q;
	assign req_fire  = req_valid & req_ready;

	// fresh request goes straight out, a refused one is replayed from the hold
	assign ar_valid = ar_hold_q | req_fire;
	assign ar_addr  = ar_hold_q ? ar_hold_addr_q : {req.pc[63:3], 3'b000};
	assign ar_prot  = AXI_PROT_INST;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ar_hold_q <= 1'b0;
		end else if (ar_hold_q) begin
			if (ar_ready) begin
				ar_hold_q <= 1'b0;
			end
		end else if (req_fire && !ar_ready) begin
			ar_hold_q <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (req_fire) begin
			ar_hold_addr_q <= {req.pc[63:3], 3'b000};
		end
	end

	// *************************************
	// tag FIFO and R channel
	// *************************************

	assign tag_any  = (cnt_q != '0);
	assign tag_head = tag_mem[rd_ptr_q];

	// R stalls with the downstream stage
	assign r_ready   = rsp_ready & tag_any;
	assign r_fire    = r_valid & r_ready;
	assign rsp_valid = r_valid & tag_any;
	assign rsp       = '{pc: tag_head.pc, epoch: tag_head.epoch, data: r_data,
		fault: (r_resp != AXI_RESP_OKAY)};

	always_ff @(posedge clk) begin
		if (req_fire) begin
			tag_mem[wr_ptr_q] <= req;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			cnt_q    <= '0;
		end else begin
			if (req_fire) begin
				wr_ptr_q <= (wr_ptr_q == PTR_LAST) ? '0 : wr_ptr_q + 1'b1;
			end
			if (r_fire) begin
				rd_ptr_q <= (rd_ptr_q == PTR_LAST) ? '0 : rd_ptr_q + 1'b1;
			end
			// in order, so pop always matches the head
			case ({req_fire, r_fire})
				2'b10:   cnt_q <= cnt_q + 1'b1;
				2'b01:   cnt_q <= cnt_q - 1'b1;
				default: cnt_q <= cnt_q;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- logic/fetch_if_id_buf.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_if_id_buf #(
	parameter int BUF_DEPTH = 4
) (
	input  wire logic                   clk,
	input  wire logic                   rst_n,
	input  wire logic                   flush,
	input  wire logic                   slot_valid,
	input  wire fetch_pkg::fetch_slot_t slot,
	output logic                        slot_ready,
	output logic                        out_valid,
	output fetch_pkg::fetch_slot_t      out_slot,
	input  wire logic                   out_ready
);

	import fetch_pkg::*;

	localparam int PTR_W = (BUF_DEPTH > 1) ? $clog2(BUF_DEPTH) : 1;
	localparam int CNT_W = $clog2(BUF_DEPTH + 1);
	localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(BUF_DEPTH - 1);
	localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(BUF_DEPTH);

	fetch_slot_t      mem [BUF_DEPTH];
	logic [PTR_W-1:0] wr_ptr_q;
	logic [PTR_W-1:0] rd_ptr_q;
	logic [CNT_W-1:0] cnt_q;
	logic             push;
	logic             pop;

	assign slot_ready = (cnt_q != CNT_FULL);
	assign out_valid  = (cnt_q != '0);
	// head entry, untouched until popped
	assign out_slot   = mem[rd_ptr_q];

	// a slot arriving with the flush is dropped too
	assign push = slot_valid & slot_ready & ~flush;
	assign pop  = out_valid & out_ready;

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr_q] <= slot;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			cnt_q    <= '0;
		end else if (flush) begin
			// empty in one cycle
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			cnt_q    <= '0;
		end else begin
			if (push) begin
				wr_ptr_q <= (wr_ptr_q == PTR_LAST) ? '0 : wr_ptr_q + 1'b1;
			end
			if (pop) begin
				rd_ptr_q <= (rd_ptr_q == PTR_LAST) ? '0 : rd_ptr_q + 1'b1;
			end
			cnt_q <= cnt_q + CNT_W'(push) - CNT_W'(pop);
		end
	end

endmodule

`default_nettype wire

//--- logic/fetch_pc_gen.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_pc_gen #(
	parameter fetch_pkg::addr_t RESET_PC = 64'h8000_0000
) (
	input  wire logic                 clk,
	input  wire logic                 rst_n,
	input  wire logic                 redirect,
	input  wire fetch_pkg::addr_t     redirect_pc,
	input  wire logic                 pred_redirect,
	input  wire fetch_pkg::addr_t     pred_target,
	output logic                      req_valid,
	output fetch_pkg::fetch_req_t     req,
	input  wire logic                 req_ready,
	output fetch_pkg::epoch_t         cur_epoch
);

	import fetch_pkg::*;

	addr_t  pc_q;
	addr_t  pc_d;
	epoch_t epoch_q;
	logic   run_q;
	logic   req_fire;
	logic   any_redirect;

	// *************************************
	// request side
	// *************************************

	// issue starts the first cycle after reset release
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			run_q <= 1'b0;
		end else begin
			run_q <= 1'b1;
		end
	end

	// always offering the current pc
	assign req_valid = run_q;
	assign req       = '{pc: pc_q, epoch: epoch_q};
	assign req_fire  = req_valid & req_ready;
	assign cur_epoch = epoch_q;

	// *************************************
	// next pc
	// *************************************

	assign any_redirect = redirect | pred_redirect;

	always_comb begin
		pc_d = pc_q;
		// execute knows better than the predictor
		if (redirect) begin
			pc_d = redirect_pc;
		end else if (pred_redirect) begin
			pc_d = pred_target;
		end else if (req_fire) begin
			// sequential, one instruction per request
			pc_d = pc_q + 64'd4;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc_q    <= RESET_PC;
			epoch_q <= EPOCH_INIT;
		end else begin
			pc_q <= pc_d;
			// one bump even if both redirects fire together
			if (any_redirect) begin
				epoch_q <= epoch_q + 2'd1;
			end
		end
	end

endmodule

`default_nettype wire

//--- logic/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

	// *************************************
	// scalar types
	// *************************************

	// byte address, full 64-bit space
	typedef logic [63:0] addr_t;
	// one 32-bit instruction
	typedef logic [31:0] inst_t;
	// flush generation, bumped by every redirect
	typedef logic [1:0] epoch_t;

	localparam epoch_t EPOCH_INIT = 2'd0;

	// opcodes the static predictor cares about
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;

	// axi4-lite response and protection codes
	localparam logic [1:0] AXI_RESP_OKAY = 2'b00;
	// unprivileged, secure, instruction fetch
	localparam logic [2:0] AXI_PROT_INST = 3'b100;

	// *************************************
	// instruction word views
	// *************************************

	// conditional branch layout, sign is imm[12]
	typedef struct packed {
		logic       sign;
		logic [5:0] imm_10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm_4_1;
		logic       imm_11;
		logic [6:0] opcode;
	} b_fmt_t;

	// jal layout, sign is imm[20]
	typedef struct packed {
		logic       sign;
		logic [9:0] imm_10_1;
		logic       imm_11;
		logic [7:0] imm_19_12;
		logic [4:0] rd;
		logic [6:0] opcode;
	} j_fmt_t;

	typedef union packed {
		inst_t  raw;
		b_fmt_t b_fmt;
		j_fmt_t j_fmt;
	} rv_inst_u;

	typedef enum logic [1:0] {
		BR_NONE = 2'd0,
		BR_COND = 2'd1,
		BR_JAL  = 2'd2
	} br_kind_e;

	// *************************************
	// stage payloads
	// *************************************

	// pc_gen -> axi_rd
	typedef struct packed {
		addr_t  pc;
		epoch_t epoch;
	} fetch_req_t;

	// axi_rd -> predecode, whole 64-bit beat
	typedef struct packed {
		addr_t       pc;
		epoch_t      epoch;
		logic [63:0] data;
		logic        fault;
	} fetch_rsp_t;

	// one instruction toward decode
	typedef struct packed {
		addr_t pc;
		inst_t inst;
		logic  pred_taken;
		// predicted next pc, pc+4 when not taken
		addr_t pred_target;
		logic  fault;
	} fetch_slot_t;

endpackage

`default_nettype wire

//--- logic/fetch_predecode.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_predecode (
	input  wire logic                  rsp_valid,
	input  wire fetch_pkg::fetch_rsp_t rsp,
	output logic                       rsp_ready,
	input  wire fetch_pkg::epoch_t     cur_epoch,
	output logic                       slot_valid,
	output fetch_pkg::fetch_slot_t     slot,
	input  wire logic                  slot_ready,
	output logic                       pred_redirect,
	output fetch_pkg::addr_t           pred_target
);

	import fetch_pkg::*;

	logic     stale;
	logic     take;
	inst_t    inst;
	rv_inst_u word;
	br_kind_e kind;
	addr_t    imm_b;
	addr_t    imm_j;
	addr_t    target;
	addr_t    next_pc;

	// *************************************
	// wrong-path filter
	// *************************************

	// older epoch means a redirect happened after issue
	assign stale = (rsp.epoch != cur_epoch);

	// stale beats are swallowed here
	assign rsp_ready  = stale | slot_ready;
	assign slot_valid = rsp_valid & ~stale;

	// *************************************
	// decode
	// *************************************

	// upper half for pc ending in 4
	assign inst = rsp.pc[2] ? rsp.data[63:32] : rsp.data[31:0];
	assign word = rv_inst_u'(inst);

	always_comb begin
		kind = BR_NONE;
		if (word.j_fmt.opcode == OPC_JAL) begin
			kind = BR_JAL;
		end else if (word.b_fmt.opcode == OPC_BRANCH) begin
			// funct3 010 and 011 are not branches
			if (word.b_fmt.funct3[2:1] != 2'b01) begin
				kind = BR_COND;
			end
		end
	end

	// sign-extended immediates, bit 0 always zero
	assign imm_b = {{51{word.b_fmt.sign}}, word.b_fmt.sign, word.b_fmt.imm_11,
		word.b_fmt.imm_10_5, word.b_fmt.imm_4_1, 1'b0};
	assign imm_j = {{43{word.j_fmt.sign}}, word.j_fmt.sign, word.j_fmt.imm_19_12,
		word.j_fmt.imm_11, word.j_fmt.imm_10_1, 1'b0};

	// *************************************
	// static prediction
	// *************************************

	// jal always, cond only backward, never on a bus error
	assign take = ~rsp.fault & ((kind == BR_JAL) | ((kind == BR_COND) & word.b_fmt.sign));

	assign target  = rsp.pc + ((kind == BR_JAL) ? imm_j : imm_b);
	assign next_pc = take ? target : rsp.pc + 64'd4;

	assign slot = '{pc: rsp.pc, inst: inst, pred_taken: take, pred_target: next_pc,
		fault: rsp.fault};

	// fires with the slot handshake, so one redirect per branch
	assign pred_redirect = slot_valid & slot_ready & take;
	assign pred_target   = target;

endmodule

`default_nettype wire

//--- logic/fetch_top.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_top #(
	parameter fetch_pkg::addr_t RESET_PC        = 64'h8000_0000,
	parameter int               MAX_OUTSTANDING = 2,
	parameter int               BUF_DEPTH       = 4
) (
	input  wire logic               clk,
	input  wire logic               rst_n,
	// from execute
	input  wire logic               redirect,
	input  wire fetch_pkg::addr_t   redirect_pc,
	// axi4-lite read master
	output logic                    ar_valid,
	output fetch_pkg::addr_t        ar_addr,
	output logic [2:0]              ar_prot,
	input  wire logic               ar_ready,
	input  wire logic               r_valid,
	input  wire logic [63:0]        r_data,
	input  wire logic [1:0]         r_resp,
	output logic                    r_ready,
	// toward decode
	output logic                    out_valid,
	output fetch_pkg::fetch_slot_t  out_slot,
	input  wire logic               out_ready
);

	import fetch_pkg::*;

	// *************************************
	// stage links
	// *************************************

	logic        req_valid;
	logic        req_ready;
	fetch_req_t  req;
	logic        rsp_valid;
	logic        rsp_ready;
	fetch_rsp_t  rsp;
	logic        slot_valid;
	logic        slot_ready;
	fetch_slot_t slot;
	logic        pred_redirect;
	addr_t       pred_target;
	epoch_t      cur_epoch;

	fetch_pc_gen #(
		.RESET_PC (RESET_PC)
	) u_pc_gen (
		.clk           (clk),
		.rst_n         (rst_n),
		.redirect      (redirect),
		.redirect_pc   (redirect_pc),
		.pred_redirect (pred_redirect),
		.pred_target   (pred_target),
		.req_valid     (req_valid),
		.req           (req),
		.req_ready     (req_ready),
		.cur_epoch     (cur_epoch)
	);

	fetch_axi_rd #(
		.MAX_OUTSTANDING (MAX_OUTSTANDING)
	) u_axi_rd (
		.clk       (clk),
		.rst_n     (rst_n),
		.req_valid (req_valid),
		.req       (req),
		.req_ready (req_ready),
		.ar_valid  (ar_valid),
		.ar_addr   (ar_addr),
		.ar_prot   (ar_prot),
		.ar_ready  (ar_ready),
		.r_valid   (r_valid),
		.r_data    (r_data),
		.r_resp    (r_resp),
		.r_ready   (r_ready),
		.rsp_valid (rsp_valid),
		.rsp       (rsp),
		.rsp_ready (rsp_ready)
	);

	fetch_predecode u_predecode (
		.rsp_valid     (rsp_valid),
		.rsp           (rsp),
		.rsp_ready     (rsp_ready),
		.cur_epoch     (cur_epoch),
		.slot_valid    (slot_valid),
		.slot          (slot),
		.slot_ready    (slot_ready),
		.pred_redirect (pred_redirect),
		.pred_target   (pred_target)
	);

	// only the external redirect flushes, predicted ones keep older slots
	fetch_if_id_buf #(
		.BUF_DEPTH (BUF_DEPTH)
	) u_if_id_buf (
		.clk        (clk),
		.rst_n      (rst_n),
		.flush      (redirect),
		.slot_valid (slot_valid),
		.slot       (slot),
		.slot_ready (slot_ready),
		.out_valid  (out_valid),
		.out_slot   (out_slot),
		.out_ready  (out_ready)
	);

endmodule

`default_nettype wire

//--- rv_fetch.f
logic/fetch_pkg.sv
logic/fetch_pc_gen.sv
logic/fetch_axi_rd.sv
logic/fetch_predecode.sv
logic/fetch_if_id_buf.sv
logic/fetch_top.sv
tb/tb_clkgen.sv
tb/tb_imem.sv
tb/fetch_sva.sv
tb/tb_fetch.sv

//--- tb/fetch_sva.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_sva (
	input wire logic                   clk,
	input wire logic                   rst_n,
	input wire logic                   ar_valid,
	input wire logic                   ar_ready,
	input wire fetch_pkg::addr_t       ar_addr,
	input wire logic                   redirect,
	input wire logic                   out_valid,
	input wire logic                   out_ready,
	input wire fetch_pkg::fetch_slot_t out_slot
);

	// AR beat held until taken
	ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
		ar_valid && !ar_ready |=> ar_valid && $stable(ar_addr))
		else $error("ar_valid or ar_addr changed before ar_ready");

	// decode side stall, flush excepted
	out_hold: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid && !out_ready && !redirect |=> out_valid && $stable(out_slot))
		else $error("out_slot changed while stalled");

	in_reset: assert property (@(posedge clk) !rst_n |-> !out_valid && !ar_valid)
		else $error("valid raised during reset");

endmodule

bind fetch_top fetch_sva u_sva (
	.clk       (clk),
	.rst_n     (rst_n),
	.ar_valid  (ar_valid),
	.ar_ready  (ar_ready),
	.ar_addr   (ar_addr),
	.redirect  (redirect),
	.out_valid (out_valid),
	.out_ready (out_ready),
	.out_slot  (out_slot)
);

`default_nettype wire

//--- tb/tb_clkgen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
	parameter int HALF_PERIOD  = 2,
	parameter int RESET_CYCLES = 16
) (
	output logic clk,
	output logic rst_n
);

	// 4 ns period
	initial begin
		clk = 1'b0;
		forever #HALF_PERIOD clk = ~clk;
	end

	// low from time zero, released on a rising edge
	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
	end

endmodule

`default_nettype wire

//--- tb/tb_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module tb_fetch;

	import fetch_pkg::*;

	localparam addr_t RESET_PC = 64'h8000_0000;
	localparam int    SEED     = 32'h305510f4;

	// instruction, secure, unprivileged
	localparam logic [2:0] PROT_INST = 3'b100;

	// *************************************
	// run length
	// *************************************

	localparam int N_STRAIGHT = 8;
	localparam int N_BACK     = 16;
	localparam int N_FWD      = 6;
	localparam int N_EXT_A    = 4;
	localparam int N_EXT_B    = 6;
	localparam int N_RAND     = 40;
	localparam int N_ERR      = 6;
	localparam int N_REDIRECT = 6;
	localparam int N_SLOTS    = N_STRAIGHT + N_BACK + N_FWD + N_EXT_A + N_EXT_B + N_RAND + N_ERR;
	localparam int LIMIT      = N_SLOTS * 8 + N_REDIRECT * 200;

	logic        clk;
	logic        rst_n;
	logic        redirect;
	addr_t       redirect_pc;
	logic        ar_valid;
	addr_t       ar_addr;
	logic [2:0]  ar_prot;
	logic        ar_ready;
	logic        r_valid;
	logic [63:0] r_data;
	logic [1:0]  r_resp;
	logic        r_ready;
	logic        out_valid;
	fetch_slot_t out_slot;
	logic        out_ready;
	int          errors = 0;
	int          tests_failed = 0;
	int          tests_run = 0;
	int          cycles = 0;
	string       cur_test = "reset";

	tb_clkgen u_clkgen (
		.clk   (clk),
		.rst_n (rst_n)
	);

	tb_imem u_imem (
		.clk      (clk),
		.rst_n    (rst_n),
		.ar_valid (ar_valid),
		.ar_addr  (ar_addr),
		.ar_ready (ar_ready),
		.r_valid  (r_valid),
		.r_data   (r_data),
		.r_resp   (r_resp),
		.r_ready  (r_ready)
	);

	fetch_top #(
		.RESET_PC        (RESET_PC),
		.MAX_OUTSTANDING (2),
		.BUF_DEPTH       (4)
	) dut (
		.clk         (clk),
		.rst_n       (rst_n),
		.redirect    (redirect),
		.redirect_pc (redirect_pc),
		.ar_valid    (ar_valid),
		.ar_addr     (ar_addr),
		.ar_prot     (ar_prot),
		.ar_ready    (ar_ready),
		.r_valid     (r_valid),
		.r_data      (r_data),
		.r_resp      (r_resp),
		.r_ready     (r_ready),
		.out_valid   (out_valid),
		.out_slot    (out_slot),
		.out_ready   (out_ready)
	);

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= LIMIT) begin
			$display("timeout: fetch stream stopped, %0d cycles without finishing", cycles);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	// *************************************
	// encoders and reference model
	// *************************************

	function automatic inst_t enc_branch(input logic [2:0] funct3, input int off);
		logic [12:0] o;
		o = off[12:0];
		return {o[12], o[10:5], 5'd2, 5'd1, funct3, o[4:1], o[11], 7'b1100011};
	endfunction

	function automatic inst_t enc_jal(input int off);
		logic [20:0] o;
		o = off[20:0];
		return {o[20], o[10:1], o[11], o[19:12], 5'd1, 7'b1101111};
	endfunction

	// jal and backward conditional branches are taken
	function automatic fetch_slot_t expect_slot(input addr_t pc);
		fetch_slot_t s;
		inst_t       w;
		w = u_imem.get_inst(pc);
		s.pc          = pc;
		s.inst        = w;
		s.fault       = u_imem.in_err(pc);
		s.pred_taken  = 1'b0;
		s.pred_target = pc + 64'd4;
		if (!s.fault && w[6:0] == 7'b1101111) begin
			s.pred_taken  = 1'b1;
			s.pred_target = pc + {{44{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
		end else if (!s.fault && w[6:0] == 7'b1100011 && w[14:13] != 2'b01 && w[31]) begin
			s.pred_taken  = 1'b1;
			s.pred_target = pc + {{52{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
		end
		return s;
	endfunction

	// *************************************
	// compare tasks
	// *************************************

	function automatic string slot_text(input fetch_slot_t s);
		return $sformatf("pc=%h inst=%h taken=%b tgt=%h fault=%b", s.pc, s.inst,
			s.pred_taken, s.pred_target, s.fault);
	endfunction

	task automatic check_slot(input string name, input fetch_slot_t exp, input fetch_slot_t act);
		if (act !== exp) begin
			errors++;
			$display("ERR %s expected %s actual %s", name, slot_text(exp), slot_text(act));
		end
	endtask

	task automatic check_fault(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			errors++;
			$display("ERR %s fault expected=%b actual=%b", name, exp, act);
		end
	endtask

	task automatic check_prot(input string name, input logic [2:0] exp, input logic [2:0] act);
		if (act !== exp) begin
			errors++;
			$display("ERR %s ar_prot expected=%b actual=%b", name, exp, act);
		end
	endtask

	// each AR beat is an instruction access
	always @(negedge clk) begin
		if (rst_n && ar_valid) begin
			check_prot(cur_test, PROT_INST, ar_prot);
		end
	end

	// *************************************
	// drivers
	// *************************************

	task automatic send_redirect(input addr_t pc);
		@(posedge clk);
		out_ready   <= 1'b0;
		redirect    <= 1'b1;
		redirect_pc <= pc;
		@(posedge clk);
		redirect <= 1'b0;
	endtask

	// take n slots from decode side and walk the reference alongside
	task automatic collect(input string name, input addr_t start, input int n, input bit jitter);
		addr_t       pc;
		fetch_slot_t exp;
		int          got;
		cur_test = name;
		pc  = start;
		got = 0;
		@(posedge clk);
		out_ready <= jitter ? 1'($urandom % 2) : 1'b1;
		while (got < n) begin
			// sampled mid-cycle so the handshake lands on the next edge
			@(negedge clk);
			if (out_valid && out_ready) begin
				exp = expect_slot(pc);
				check_slot(name, exp, out_slot);
				check_fault(name, exp.fault, out_slot.fault);
				pc = exp.pred_target;
				got++;
			end
			@(posedge clk);
			if (got < n) begin
				out_ready <= jitter ? 1'($urandom % 2) : 1'b1;
			end else begin
				out_ready <= 1'b0;
			end
		end
	endtask

	task automatic report(input string name, input int err_before);
		tests_run++;
		if (errors == err_before) begin
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: failed with %0d errors", name, errors - err_before);
		end
	endtask

	// *************************************
	// tests
	// *************************************

	// the fill pattern holds no branches
	task automatic test_straight();
		int e;
		e = errors;
		collect("straight", RESET_PC, N_STRAIGHT, 1'b0);
		report("straight", e);
	endtask

	task automatic test_backward();
		addr_t b;
		int    e;
		b = 64'h8000_1000;
		e = errors;
		// funct3 010 looks like a branch but is not one
		u_imem.put_inst(b + 64'h04, enc_branch(3'b010, -4));
		u_imem.put_inst(b + 64'h0c, enc_jal(32'h40));
		u_imem.put_inst(b + 64'h54, enc_branch(3'b000, -32'h14));
		send_redirect(b);
		collect("backward", b, N_BACK, 1'b0);
		report("backward", e);
	endtask

	task automatic test_forward();
		addr_t b;
		int    e;
		b = 64'h8000_2000;
		e = errors;
		u_imem.put_inst(b + 64'h04, enc_branch(3'b001, 32'h20));
		send_redirect(b);
		collect("forward", b, N_FWD, 1'b0);
		report("forward", e);
	endtask

	task automatic test_ext_redirect();
		addr_t a;
		int    e;
		a = 64'h8000_3000;
		e = errors;
		send_redirect(a);
		collect("ext_redirect", a, N_EXT_A, 1'b0);
		// let old-path slots pile up in the buffer
		repeat (12) @(posedge clk);
		send_redirect(a + 64'h404);
		collect("ext_redirect", a + 64'h404, N_EXT_B, 1'b0);
		report("ext_redirect", e);
	endtask

	task automatic test_random();
		addr_t b;
		int    e;
		b = 64'h8000_4000;
		e = errors;
		u_imem.put_inst(b + 64'h004, enc_branch(3'b101, 32'h40));
		u_imem.put_inst(b + 64'h010, enc_jal(32'h100));
		u_imem.put_inst(b + 64'h120, enc_branch(3'b100, -32'h120));
		send_redirect(b);
		collect("random", b, N_RAND, 1'b1);
		report("random", e);
	endtask

	task automatic test_bus_error();
		addr_t b;
		int    e;
		b = 64'h8000_5000;
		e = errors;
		// both halves of one beat fault and the jal inside stays untaken
		u_imem.set_err_window(b + 64'h08, b + 64'h10);
		u_imem.put_inst(b + 64'h0c, enc_jal(32'h80));
		send_redirect(b);
		collect("bus_error", b, N_ERR, 1'b0);
		report("bus_error", e);
	endtask

	initial begin
		void'($urandom(SEED));
		redirect    = 1'b0;
		redirect_pc = '0;
		out_ready   = 1'b0;
		wait (rst_n === 1'b1);
		test_straight();
		test_backward();
		test_forward();
		test_ext_redirect();
		test_random();
		test_bus_error();
		$display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- tb/tb_imem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_imem (
	input  wire logic             clk,
	input  wire logic             rst_n,
	input  wire logic             ar_valid,
	input  wire fetch_pkg::addr_t ar_addr,
	output logic                  ar_ready,
	output logic                  r_valid,
	output logic [63:0]           r_data,
	output logic [1:0]            r_resp,
	input  wire logic             r_ready
);

	import fetch_pkg::*;

	localparam int WORDS = 4096;

	// 32 KB window, aliased on address bits 14:3
	logic [63:0] mem [WORDS];
	addr_t       pend [$];
	addr_t       head;
	addr_t       err_lo = '0;
	addr_t       err_hi = '0;
	int          lat = 0;
	logic        ar_ready_q = 1'b0;
	logic        r_valid_q = 1'b0;
	logic [63:0] r_data_q = '0;
	logic [1:0]  r_resp_q = 2'b00;

	assign ar_ready = ar_ready_q;
	assign r_valid  = r_valid_q;
	assign r_data   = r_data_q;
	assign r_resp   = r_resp_q;

	// addi x1,x1,imm with imm folded from every address bit
	function automatic inst_t fill_inst(input addr_t a);
		logic [11:0] fold;
		fold = a[13:2] ^ a[25:14] ^ a[37:26] ^ a[49:38] ^ a[61:50] ^ {10'b0, a[63:62]};
		return {fold, 5'd1, 3'b000, 5'd1, 7'b0010011};
	endfunction

	initial begin
		addr_t a;
		for (int i = 0; i < WORDS; i++) begin
			a = 64'h8000_0000 + 64'(i) * 64'd8;
			mem[i] = {fill_inst(a + 64'd4), fill_inst(a)};
		end
	end

	// *************************************
	// access from the testbench
	// *************************************

	function automatic inst_t get_inst(input addr_t a);
		logic [63:0] w;
		w = mem[a[14:3]];
		return a[2] ? w[63:32] : w[31:0];
	endfunction

	task automatic put_inst(input addr_t a, input inst_t v);
		if (a[2]) begin
			mem[a[14:3]][63:32] = v;
		end else begin
			mem[a[14:3]][31:0] = v;
		end
	endtask

	function automatic logic in_err(input addr_t a);
		return (a >= err_lo) && (a < err_hi);
	endfunction

	task automatic set_err_window(input addr_t lo, input addr_t hi);
		err_lo = lo;
		err_hi = hi;
	endtask

	// *************************************
	// AR and R channels
	// *************************************

	// in order, 0 to 3 idle cycles before each beat
	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ar_ready_q <= 1'b0;
			r_valid_q  <= 1'b0;
			r_data_q   <= '0;
			r_resp_q   <= 2'b00;
			pend.delete();
			lat = 0;
		end else begin
			if (ar_valid && ar_ready_q) begin
				pend.push_back(ar_addr);
			end
			if (!r_valid_q || r_ready) begin
				r_valid_q <= 1'b0;
				if (pend.size() > 0) begin
					if (lat > 0) begin
						lat = lat - 1;
					end else begin
						head = pend.pop_front();
						r_valid_q <= 1'b1;
						// data is real even on slverr
						r_data_q  <= mem[head[14:3]];
						r_resp_q  <= in_err(head) ? 2'b10 : 2'b00;
						lat = int'($urandom % 4);
					end
				end
			end
			// random AR stalls, bounded queue
			ar_ready_q <= (pend.size() < 3) && ($urandom % 4 != 0);
		end
	end

endmodule

`default_nettype wire
